// File: verilog/exec_defines.svh
`ifndef EXEC_DEFINES_SVH
`define EXEC_DEFINES_SVH

// data word and instruction address width.
`define EXEC_XLEN 32

// width of the ALU operation code.
`define EXEC_ALU_OP_W 5

// width of the next-PC and write-back select codes.
`define EXEC_SEL_W 2

// width of the operand A and operand B select codes.
`define EXEC_OPSEL_W 3

`endif

// File: verilog/exec_data_pkg.sv
`default_nettype none

`include "exec_defines.svh"

package exec_data_pkg;

  typedef logic [`EXEC_XLEN-1:0] word_t;
  typedef logic [`EXEC_XLEN-1:0] pc_t;

  // compare operations return 0 or 1 in bit 0.
  typedef enum logic [`EXEC_ALU_OP_W-1:0] {
    alu_add    = 'd0,
    alu_sub    = 'd1,
    alu_and    = 'd2,
    alu_or     = 'd3,
    alu_xor    = 'd4,
    alu_sll    = 'd5,
    alu_srl    = 'd6,
    alu_sra    = 'd7,
    alu_slt    = 'd8,
    alu_sltu   = 'd9,
    alu_eq     = 'd10,  // branch compares start here.
    alu_ne     = 'd11,
    alu_lt     = 'd12,
    alu_ge     = 'd13,
    alu_ltu    = 'd14,
    alu_geu    = 'd15,
    alu_pass_b = 'd16   // lui and csr immediates.
  } alu_op_t;

endpackage

`default_nettype wire

// File: verilog/exec_ctrl_pkg.sv
`default_nettype none

`include "exec_defines.svh"

package exec_ctrl_pkg;

  typedef enum logic [`EXEC_SEL_W-1:0] {
    npc_seq    = 'd0,  // pc+4.
    npc_jal    = 'd1,  // pc+imm.
    npc_jalr   = 'd2,  // alu result with bit 0 cleared.
    npc_branch = 'd3   // pc+imm when result bit 0 is set.
  } npc_sel_t;

  typedef enum logic [`EXEC_SEL_W-1:0] {
    wb_alu    = 'd0,
    wb_link   = 'd1,  // pc+4 for jal and jalr.
    wb_pc_imm = 'd2,  // auipc.
    wb_csr    = 'd3   // old csr value.
  } wb_sel_t;

  typedef enum logic [`EXEC_OPSEL_W-1:0] {
    opa_reg      = 'd0,
    opa_bypass   = 'd1,
    opa_feedback = 'd2
  } opa_sel_t;

  // bypass and feedback also steer the store data.
  typedef enum logic [`EXEC_OPSEL_W-1:0] {
    opb_reg      = 'd0,
    opb_imm      = 'd1,
    opb_csr      = 'd2,
    opb_bypass   = 'd3,
    opb_feedback = 'd4
  } opb_sel_t;

endpackage

`default_nettype wire

// File: verilog/exec_alu.sv
`timescale 1ns/1ns
`default_nettype none

`include "exec_defines.svh"

module exec_alu (
  input  exec_data_pkg::alu_op_t op,
  input  exec_data_pkg::word_t   a,
  input  exec_data_pkg::word_t   b,
  output exec_data_pkg::word_t   result
);

  localparam int shamt_w = $clog2(`EXEC_XLEN);

  logic [shamt_w-1:0] shamt;
  logic               lt_s;
  logic               lt_u;
  logic               eq;

  assign shamt = b[shamt_w-1:0];  // only the low bits count for shifts.
  assign lt_s  = $signed(a) < $signed(b);
  assign lt_u  = a < b;
  assign eq    = a == b;

  always_comb begin
    result = '0;
    case (op)
      exec_data_pkg::alu_add: result = a + b;
      exec_data_pkg::alu_sub: result = a - b;
      exec_data_pkg::alu_and: result = a & b;
      exec_data_pkg::alu_or:  result = a | b;
      exec_data_pkg::alu_xor: result = a ^ b;
      exec_data_pkg::alu_sll: result = a << shamt;
      exec_data_pkg::alu_srl: result = a >> shamt;
      exec_data_pkg::alu_sra: result = $signed(a) >>> shamt;
      exec_data_pkg::alu_slt: result[0] = lt_s;
      exec_data_pkg::alu_sltu: result[0] = lt_u;
      exec_data_pkg::alu_eq: result[0] = eq;
      exec_data_pkg::alu_ne: result[0] = !eq;
      exec_data_pkg::alu_lt: result[0] = lt_s;
      exec_data_pkg::alu_ge: result[0] = !lt_s;
      exec_data_pkg::alu_ltu: result[0] = lt_u;
      exec_data_pkg::alu_geu: result[0] = !lt_u;
      exec_data_pkg::alu_pass_b: result = b;
      default: result = '0;  // unused codes give zero.
    endcase
  end

endmodule

`default_nettype wire

// File: verilog/exec_operand_mux.sv
`timescale 1ns/1ns
`default_nettype none

`include "exec_defines.svh"

module exec_operand_mux (
  input  exec_ctrl_pkg::opa_sel_t opa_sel,
  input  exec_ctrl_pkg::opb_sel_t opb_sel,
  input  exec_data_pkg::word_t    src1,
  input  exec_data_pkg::word_t    src2,
  input  exec_data_pkg::word_t    imm,
  input  exec_data_pkg::word_t    csr_src,
  input  exec_data_pkg::word_t    bypass_data,
  input  exec_data_pkg::word_t    feedback_data,
  output exec_data_pkg::word_t    operand_a,
  output exec_data_pkg::word_t    operand_b,
  output exec_data_pkg::word_t    store_src
);

  logic [`EXEC_XLEN-1:0] src2_fwd;

  always_comb begin
    case (opa_sel)
      exec_ctrl_pkg::opa_bypass:   operand_a = bypass_data;
      exec_ctrl_pkg::opa_feedback: operand_a = feedback_data;  // previous write-back value.
      default:                     operand_a = src1;
    endcase
  end

  // src2 after forwarding, without the immediate or csr choices.
  always_comb begin
    case (opb_sel)
      exec_ctrl_pkg::opb_bypass:   src2_fwd = bypass_data;
      exec_ctrl_pkg::opb_feedback: src2_fwd = feedback_data;
      default:                     src2_fwd = src2;
    endcase
  end

  always_comb begin
    case (opb_sel)
      exec_ctrl_pkg::opb_imm: operand_b = imm;
      exec_ctrl_pkg::opb_csr: operand_b = csr_src;
      default:                operand_b = src2_fwd;
    endcase
  end

  // a store with an immediate offset still stores the forwarded rs2.
  assign store_src = src2_fwd;

endmodule

`default_nettype wire

// File: verilog/exec_stage.sv
`timescale 1ns/1ns
`default_nettype none

`include "exec_defines.svh"

module exec_stage (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    stall,
  input  logic                    flush,
  input  logic                    issue_valid,
  input  exec_data_pkg::pc_t      issue_pc,
  input  exec_data_pkg::word_t    imm,
  input  exec_data_pkg::word_t    csr_src,
  input  exec_data_pkg::alu_op_t  alu_op,
  input  exec_ctrl_pkg::npc_sel_t npc_sel,
  input  exec_ctrl_pkg::wb_sel_t  wb_sel,
  input  exec_data_pkg::word_t    operand_a,
  input  exec_data_pkg::word_t    operand_b,
  input  exec_data_pkg::word_t    store_src,
  input  exec_data_pkg::word_t    alu_result,
  output exec_data_pkg::alu_op_t  alu_op_q,
  output exec_data_pkg::word_t    alu_a,
  output exec_data_pkg::word_t    alu_b,
  output logic                    exec_valid,
  output exec_data_pkg::pc_t      exec_pc,
  output exec_data_pkg::pc_t      next_pc,
  output exec_data_pkg::word_t    wb_data,
  output exec_data_pkg::word_t    csr_wdata,
  output exec_data_pkg::word_t    store_data,
  output logic                    redirect
);

  localparam exec_data_pkg::pc_t pc_step = exec_data_pkg::pc_t'(4);

  logic                    valid_q;
  exec_ctrl_pkg::npc_sel_t npc_sel_q;
  exec_ctrl_pkg::wb_sel_t  wb_sel_q;
  exec_data_pkg::pc_t      pc_q;
  exec_data_pkg::pc_t      snpc_q;
  exec_data_pkg::pc_t      dnpc_q;
  exec_data_pkg::word_t    csr_q;
  exec_data_pkg::word_t    store_q;
  exec_data_pkg::alu_op_t  op_q;
  exec_data_pkg::word_t    a_q;
  exec_data_pkg::word_t    b_q;

  // flush wins over stall, so a flushed slot never comes back.
  always_ff @(posedge clock) begin
    if (reset) begin
      valid_q   <= 1'b0;
      npc_sel_q <= exec_ctrl_pkg::npc_seq;
      wb_sel_q  <= exec_ctrl_pkg::wb_alu;
    end else begin
      if (flush) begin
        valid_q <= 1'b0;
      end else if (!stall) begin
        valid_q <= issue_valid;
      end
      if (!stall) begin
        npc_sel_q <= npc_sel;
        wb_sel_q  <= wb_sel;
      end
    end
  end

  // fields are taken on every unstalled edge, valid or not.
  always_ff @(posedge clock) begin
    if (!stall) begin
      pc_q    <= issue_pc;
      snpc_q  <= issue_pc + pc_step;  // both targets are ready before the alu settles.
      dnpc_q  <= issue_pc + imm;
      csr_q   <= csr_src;
      store_q <= store_src;
      op_q    <= alu_op;
      a_q     <= operand_a;
      b_q     <= operand_b;
    end
  end

  always_comb begin
    case (npc_sel_q)
      exec_ctrl_pkg::npc_jal:    next_pc = dnpc_q;
      exec_ctrl_pkg::npc_jalr:   next_pc = {alu_result[`EXEC_XLEN-1:1], 1'b0};
      exec_ctrl_pkg::npc_branch: next_pc = alu_result[0] ? dnpc_q : snpc_q;
      default:                   next_pc = snpc_q;
    endcase
  end

  always_comb begin
    case (wb_sel_q)
      exec_ctrl_pkg::wb_link:   wb_data = snpc_q;
      exec_ctrl_pkg::wb_pc_imm: wb_data = dnpc_q;
      exec_ctrl_pkg::wb_csr:    wb_data = csr_q;  // csr read returns the old value.
      default:                  wb_data = alu_result;
    endcase
  end

  assign alu_op_q   = op_q;
  assign alu_a      = a_q;
  assign alu_b      = b_q;
  assign exec_valid = valid_q;
  assign exec_pc    = pc_q;
  assign csr_wdata  = alu_result;
  assign store_data = store_q;

  // no prediction, so every non-sequential instruction redirects fetch.
  assign redirect = valid_q && (npc_sel_q != exec_ctrl_pkg::npc_seq);

endmodule

`default_nettype wire

// File: verilog/exec_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "exec_defines.svh"

module exec_top (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    stall,
  input  logic                    flush,
  input  logic                    issue_valid,
  input  exec_data_pkg::pc_t      issue_pc,
  input  exec_data_pkg::word_t    imm,
  input  exec_data_pkg::word_t    src1,
  input  exec_data_pkg::word_t    src2,
  input  exec_data_pkg::word_t    csr_src,
  input  exec_data_pkg::word_t    bypass_data,
  input  exec_data_pkg::alu_op_t  alu_op,
  input  exec_ctrl_pkg::opa_sel_t opa_sel,
  input  exec_ctrl_pkg::opb_sel_t opb_sel,
  input  exec_ctrl_pkg::npc_sel_t npc_sel,
  input  exec_ctrl_pkg::wb_sel_t  wb_sel,
  output logic                    exec_valid,
  output exec_data_pkg::pc_t      exec_pc,
  output exec_data_pkg::pc_t      next_pc,
  output exec_data_pkg::word_t    wb_data,
  output exec_data_pkg::word_t    csr_wdata,
  output exec_data_pkg::word_t    store_data,
  output logic                    redirect
);

  logic [`EXEC_XLEN-1:0]  operand_a;
  logic [`EXEC_XLEN-1:0]  operand_b;
  logic [`EXEC_XLEN-1:0]  store_src;
  logic [`EXEC_XLEN-1:0]  alu_a;
  logic [`EXEC_XLEN-1:0]  alu_b;
  logic [`EXEC_XLEN-1:0]  alu_result;
  exec_data_pkg::alu_op_t alu_op_q;

  // feedback comes from the write-back value on the outputs this cycle.
  exec_operand_mux operand_mux0 (
    .opa_sel       (opa_sel),
    .opb_sel       (opb_sel),
    .src1          (src1),
    .src2          (src2),
    .imm           (imm),
    .csr_src       (csr_src),
    .bypass_data   (bypass_data),
    .feedback_data (wb_data),
    .operand_a     (operand_a),
    .operand_b     (operand_b),
    .store_src     (store_src)
  );

  exec_stage stage0 (
    .clock       (clock),
    .reset       (reset),
    .stall       (stall),
    .flush       (flush),
    .issue_valid (issue_valid),
    .issue_pc    (issue_pc),
    .imm         (imm),
    .csr_src     (csr_src),
    .alu_op      (alu_op),
    .npc_sel     (npc_sel),
    .wb_sel      (wb_sel),
    .operand_a   (operand_a),
    .operand_b   (operand_b),
    .store_src   (store_src),
    .alu_result  (alu_result),
    .alu_op_q    (alu_op_q),
    .alu_a       (alu_a),
    .alu_b       (alu_b),
    .exec_valid  (exec_valid),
    .exec_pc     (exec_pc),
    .next_pc     (next_pc),
    .wb_data     (wb_data),
    .csr_wdata   (csr_wdata),
    .store_data  (store_data),
    .redirect    (redirect)
  );

  exec_alu alu0 (
    .op     (alu_op_q),
    .a      (alu_a),
    .b      (alu_b),
    .result (alu_result)
  );

endmodule

`default_nettype wire

// File: tests/exec_assert.sv
`timescale 1ns/1ns
`default_nettype none

module exec_assert (
  input logic                    clock,
  input logic                    reset,
  input logic                    stall,
  input logic                    flush,
  input logic                    issue_valid,
  input exec_ctrl_pkg::npc_sel_t npc_sel,
  input logic                    exec_valid,
  input logic                    redirect,
  input exec_data_pkg::pc_t      exec_pc,
  input exec_data_pkg::pc_t      next_pc,
  input exec_data_pkg::word_t    wb_data,
  input exec_data_pkg::word_t    csr_wdata,
  input exec_data_pkg::word_t    store_data
);

  int failures = 0;

  // an accepted jump or branch redirects fetch in the next cycle.
  redirect_follows_issue: assert property (@(posedge clock) disable iff (reset)
    (!stall && !flush && issue_valid && (npc_sel != exec_ctrl_pkg::npc_seq)) |=> redirect)
    else begin
      failures = failures + 1;
      $error("accepted jump or branch did not raise redirect");
    end

  flush_clears_valid: assert property (@(posedge clock) disable iff (reset)
    flush |=> !exec_valid)
    else begin
      failures = failures + 1;
      $error("valid instruction survived a flush");
    end

  // a flush may still drop the held slot, so only the data must hold.
  stall_holds_data: assert property (@(posedge clock) disable iff (reset)
    stall |=> $stable(exec_pc) && $stable(next_pc) && $stable(wb_data)
              && $stable(csr_wdata) && $stable(store_data))
    else begin
      failures = failures + 1;
      $error("outputs changed across a stalled cycle");
    end

  stall_holds_valid: assert property (@(posedge clock) disable iff (reset)
    (stall && !flush) |=> $stable(exec_valid) && $stable(redirect))
    else begin
      failures = failures + 1;
      $error("valid or redirect changed across a stalled cycle");
    end

endmodule

bind exec_stage exec_assert stage_assert0 (.*);

`default_nettype wire

// File: tests/tb_exec_top.sv
`timescale 1ns/1ns
`default_nettype none

module tb_exec_top;

  localparam int reset_cycles     = 8;
  localparam int num_issues       = 400;
  localparam int max_issue_cycles = 6;
  localparam int cycle_limit      = num_issues * max_issue_cycles;

  typedef struct packed {
    exec_data_pkg::pc_t      pc;
    exec_data_pkg::word_t    imm;
    exec_data_pkg::word_t    src1;
    exec_data_pkg::word_t    src2;
    exec_data_pkg::word_t    csr;
    exec_data_pkg::word_t    bypass;
    exec_data_pkg::alu_op_t  op;
    exec_ctrl_pkg::opa_sel_t opa;
    exec_ctrl_pkg::opb_sel_t opb;
    exec_ctrl_pkg::npc_sel_t npc;
    exec_ctrl_pkg::wb_sel_t  wb;
  } issue_t;

  typedef struct packed {
    exec_data_pkg::word_t alu;
    exec_data_pkg::pc_t   npc;
    exec_data_pkg::word_t wb;
    exec_data_pkg::word_t store;
  } expect_t;

  logic                    clock = 1'b0;
  logic                    reset;
  logic                    stall;
  logic                    flush;
  logic                    issue_valid;
  exec_data_pkg::pc_t      issue_pc;
  exec_data_pkg::word_t    imm;
  exec_data_pkg::word_t    src1;
  exec_data_pkg::word_t    src2;
  exec_data_pkg::word_t    csr_src;
  exec_data_pkg::word_t    bypass_data;
  exec_data_pkg::alu_op_t  alu_op;
  exec_ctrl_pkg::opa_sel_t opa_sel;
  exec_ctrl_pkg::opb_sel_t opb_sel;
  exec_ctrl_pkg::npc_sel_t npc_sel;
  exec_ctrl_pkg::wb_sel_t  wb_sel;
  logic                    exec_valid;
  exec_data_pkg::pc_t      exec_pc;
  exec_data_pkg::pc_t      next_pc;
  exec_data_pkg::word_t    wb_data;
  exec_data_pkg::word_t    csr_wdata;
  exec_data_pkg::word_t    store_data;
  logic                    redirect;

  int                   seed = 24049;
  int                   accepted = 0;
  int                   cycle_count = 0;
  logic                 model_live = 1'b0;
  logic                 slot_valid = 1'b0;
  issue_t               slot;
  exec_data_pkg::word_t slot_fb;  // write-back value seen by the slot when it was issued.

  exec_top dut0 (.*);

  always #2 clock = ~clock;

  task automatic report_failure(string msg);
    $display("%s", msg);
    $display("TEST FAIL");
    $fatal(1);
  endtask

  task automatic check_word(string name, exec_data_pkg::word_t expected,
                            exec_data_pkg::word_t actual);
    if (actual !== expected) begin
      report_failure($sformatf("error %s: expected %h, actual %h", name, expected, actual));
    end
  endtask

  task automatic check_pc(string name, exec_data_pkg::pc_t expected, exec_data_pkg::pc_t actual);
    if (actual !== expected) begin
      report_failure($sformatf("error %s: expected %h, actual %h", name, expected, actual));
    end
  endtask

  task automatic check_bit(string name, logic expected, logic actual);
    if (actual !== expected) begin
      report_failure($sformatf("error %s: expected %b, actual %b", name, expected, actual));
    end
  endtask

  function automatic int rand_below(int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  function automatic exec_data_pkg::word_t rand_word();
    return $random(seed);
  endfunction

  function automatic issue_t current_issue();
    issue_t s;
    s = '{issue_pc, imm, src1, src2, csr_src, bypass_data, alu_op, opa_sel, opb_sel,
          npc_sel, wb_sel};
    return s;
  endfunction

  function automatic string label(string field);
    return $sformatf("random_issues op %s %s", slot.op.name(), field);
  endfunction

  // expected outputs for a captured issue, with fb as the feedback value.
  function automatic expect_t reference_result(issue_t s, exec_data_pkg::word_t fb);
    expect_t              e;
    exec_data_pkg::word_t a;
    exec_data_pkg::word_t b;
    exec_data_pkg::word_t fwd2;
    exec_data_pkg::pc_t   seq_pc;
    exec_data_pkg::pc_t   tgt_pc;
    logic [4:0]           sh;
    logic                 lt_s;
    logic                 lt_u;
    a = (s.opa == exec_ctrl_pkg::opa_bypass) ? s.bypass :
        (s.opa == exec_ctrl_pkg::opa_feedback) ? fb : s.src1;
    fwd2 = (s.opb == exec_ctrl_pkg::opb_bypass) ? s.bypass :
           (s.opb == exec_ctrl_pkg::opb_feedback) ? fb : s.src2;
    b = (s.opb == exec_ctrl_pkg::opb_imm) ? s.imm :
        (s.opb == exec_ctrl_pkg::opb_csr) ? s.csr : fwd2;
    sh = b[4:0];
    lt_u = a < b;
    lt_s = (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000);  // flipping the sign bits orders signed values.
    e.alu = '0;
    case (s.op)
      exec_data_pkg::alu_add:    e.alu = a + b;
      exec_data_pkg::alu_sub:    e.alu = a - b;
      exec_data_pkg::alu_and:    e.alu = a & b;
      exec_data_pkg::alu_or:     e.alu = a | b;
      exec_data_pkg::alu_xor:    e.alu = a ^ b;
      exec_data_pkg::alu_sll:    e.alu = a << sh;
      exec_data_pkg::alu_srl:    e.alu = a >> sh;
      exec_data_pkg::alu_sra:    e.alu = (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
      exec_data_pkg::alu_slt:    e.alu[0] = lt_s;
      exec_data_pkg::alu_sltu:   e.alu[0] = lt_u;
      exec_data_pkg::alu_eq:     e.alu[0] = (a == b);
      exec_data_pkg::alu_ne:     e.alu[0] = (a != b);
      exec_data_pkg::alu_lt:     e.alu[0] = lt_s;
      exec_data_pkg::alu_ge:     e.alu[0] = !lt_s;
      exec_data_pkg::alu_ltu:    e.alu[0] = lt_u;
      exec_data_pkg::alu_geu:    e.alu[0] = !lt_u;
      exec_data_pkg::alu_pass_b: e.alu = b;
      default:                   e.alu = '0;
    endcase
    seq_pc = s.pc + 32'd4;
    tgt_pc = s.pc + s.imm;
    case (s.npc)
      exec_ctrl_pkg::npc_jal:    e.npc = tgt_pc;
      exec_ctrl_pkg::npc_jalr:   e.npc = {e.alu[31:1], 1'b0};
      exec_ctrl_pkg::npc_branch: e.npc = e.alu[0] ? tgt_pc : seq_pc;
      default:                   e.npc = seq_pc;
    endcase
    case (s.wb)
      exec_ctrl_pkg::wb_link:   e.wb = seq_pc;
      exec_ctrl_pkg::wb_pc_imm: e.wb = tgt_pc;
      exec_ctrl_pkg::wb_csr:    e.wb = s.csr;
      default:                  e.wb = e.alu;
    endcase
    e.store = fwd2;
    return e;
  endfunction

  task automatic drive_random_issue();
    issue_valid = rand_below(100) < 85;
    stall       = rand_below(100) < 20;
    flush       = rand_below(100) < 6;
    issue_pc    = rand_word();
    imm         = rand_word();
    src1        = rand_word();
    src2        = (rand_below(8) == 0) ? src1 : rand_word();  // equal operands for eq and ge.
    csr_src     = rand_word();
    bypass_data = rand_word();
    alu_op      = exec_data_pkg::alu_op_t'(rand_below(17));
    opa_sel     = exec_ctrl_pkg::opa_sel_t'(rand_below(3));
    opb_sel     = exec_ctrl_pkg::opb_sel_t'(rand_below(5));
    npc_sel     = exec_ctrl_pkg::npc_sel_t'(rand_below(4));
    wb_sel      = exec_ctrl_pkg::wb_sel_t'(rand_below(4));
  endtask

  // the model mirrors the pipeline register, valid or not, since feedback uses it.
  always @(posedge clock) begin
    expect_t cur;
    cur = reference_result(slot, slot_fb);
    if (!stall) begin
      slot_fb = cur.wb;
      slot    = current_issue();
    end
    if (reset) begin
      slot.npc   = exec_ctrl_pkg::npc_seq;
      slot.wb    = exec_ctrl_pkg::wb_alu;
      slot_valid = 1'b0;
    end else if (flush) begin
      slot_valid = 1'b0;
    end else if (!stall) begin
      slot_valid = issue_valid;
    end
    if (!reset && !stall && issue_valid) begin
      accepted = accepted + 1;
    end
    model_live = 1'b1;
  end

  always @(negedge clock) begin
    expect_t exp;
    if (model_live) begin
      exp = reference_result(slot, slot_fb);
      check_bit(label("exec_valid"), slot_valid, exec_valid);
      check_bit(label("redirect"), slot_valid && (slot.npc != exec_ctrl_pkg::npc_seq), redirect);
      if (slot_valid) begin
        check_pc(label("exec_pc"), slot.pc, exec_pc);
        check_pc(label("next_pc"), exp.npc, next_pc);
        check_word(label("wb_data"), exp.wb, wb_data);
        check_word(label("csr_wdata"), exp.alu, csr_wdata);
        check_word(label("store_data"), exp.store, store_data);
      end
    end
  end

  always @(posedge clock) begin
    if (!reset) begin
      cycle_count = cycle_count + 1;
    end
    if (cycle_count > cycle_limit) begin
      report_failure($sformatf("timeout: the run did not finish within %0d cycles", cycle_limit));
    end
  end

  always @(dut0.stage0.stage_assert0.failures) begin
    if (dut0.stage0.stage_assert0.failures != 0) begin
      report_failure("a stage assertion failed during the run");
    end
  end

  initial begin
    reset       = 1'b1;
    stall       = 1'b0;
    flush       = 1'b0;
    issue_valid = 1'b0;
    issue_pc    = '0;
    imm         = '0;
    src1        = '0;
    src2        = '0;
    csr_src     = '0;
    bypass_data = '0;
    alu_op      = exec_data_pkg::alu_add;
    opa_sel     = exec_ctrl_pkg::opa_reg;
    opb_sel     = exec_ctrl_pkg::opb_reg;
    npc_sel     = exec_ctrl_pkg::npc_seq;
    wb_sel      = exec_ctrl_pkg::wb_alu;
    repeat (reset_cycles) @(posedge clock);
    #1 reset = 1'b0;
    while (accepted < num_issues) begin
      @(posedge clock);
      #1;
      if (accepted < num_issues) begin
        drive_random_issue();
      end
    end
    issue_valid = 1'b0;
    stall       = 1'b0;
    flush       = 1'b0;
    repeat (3) @(posedge clock);
    #1;
    $display("TEST PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: compile.f
+incdir+verilog
verilog/exec_data_pkg.sv
verilog/exec_ctrl_pkg.sv
verilog/exec_alu.sv
verilog/exec_operand_mux.sv
verilog/exec_stage.sv
verilog/exec_top.sv
tests/exec_assert.sv
tests/tb_exec_top.sv

// File: Bender.yml
package:
  name: exec_stage

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/exec_data_pkg.sv
      - verilog/exec_ctrl_pkg.sv
      - verilog/exec_alu.sv
      - verilog/exec_operand_mux.sv
      - verilog/exec_stage.sv
      - verilog/exec_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - tests/exec_assert.sv
      - tests/tb_exec_top.sv
